// ==== design/execDefs_macros.svh ====
`ifndef EXEC_DEFS_MACROS_SVH
`define EXEC_DEFS_MACROS_SVH

// datapath and address width
`define XLEN     32

// rename tag width
`define NICK_W   4

// reservation station entries
`define RS_DEPTH 4

// result queue entries, also the initial credit count
`define RQ_DEPTH 4

// fall-through pc increment
`define PC_STEP  4

`endif

// ==== design/execPkg.sv ====
package execPkg;

    // internal opcodes after decode
    typedef enum logic [4:0] {
        LUI,
        AUIPC,
        JAL,
        JALR,
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU,
        ADDI,   // immediate forms
        SLTI,
        SLTIU,
        XORI,
        ORI,
        ANDI,
        SLLI,
        SRLI,
        SRAI,
        ADD,    // register forms
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND
    } aluOp_e;

    typedef enum logic {NotJump, Jump} jumpFlag_e;

endpackage

// ==== design/issueIf.sv ====
`timescale 1ns/1ps
`include "execDefs_macros.svh"

// one issued instruction, station to alu
interface issueIf import execPkg::*; ();
    logic               en;     // single-cycle pulse
    logic [`XLEN-1:0]   pc;
    aluOp_e             op;
    logic [`XLEN-1:0]   imm;
    logic [`NICK_W-1:0] nick;   // destination tag
    logic [`XLEN-1:0]   rs1;
    logic [`XLEN-1:0]   rs2;

    modport src (
        output en, pc, op, imm, nick, rs1, rs2
    );

    modport sink (
        input en, pc, op, imm, nick, rs1, rs2
    );
endinterface

// ==== design/cdbIf.sv ====
`timescale 1ns/1ps
`include "execDefs_macros.svh"

interface cdbIf import execPkg::*; ();
    logic               en;
    logic [`NICK_W-1:0] nick;
    logic [`XLEN-1:0]   dt;
    jumpFlag_e          ac;     // branch/jump taken
    logic [`XLEN-1:0]   jPc;    // next pc

    modport src   (output en, nick, dt, ac, jPc);
    modport snoop (input  en, nick, dt, ac, jPc);
endinterface

// ==== design/reservationStation.sv ====
`timescale 1ns/1ps
`include "execDefs_macros.svh"

module reservationStation import execPkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               rdy,
    input  logic               dispEn,
    input  logic [`XLEN-1:0]   dispPc,
    input  aluOp_e             dispOp,
    input  logic [`XLEN-1:0]   dispImm,
    input  logic [`NICK_W-1:0] dispNick,
    input  logic [`XLEN-1:0]   dispRs1Val,
    input  logic [`NICK_W-1:0] dispRs1Tag,
    input  logic               dispRs1Busy,
    input  logic [`XLEN-1:0]   dispRs2Val,
    input  logic [`NICK_W-1:0] dispRs2Tag,
    input  logic               dispRs2Busy,
    output logic               dispFull,
    input  logic               popDone,
    issueIf.src                issue,
    cdbIf.snoop                cdb
);
    localparam int IdxW  = $clog2(`RS_DEPTH);
    localparam int CredW = $clog2(`RQ_DEPTH + 1);

    typedef struct packed {
        logic               valid;
        logic [`NICK_W-1:0] tag;
        logic [`XLEN-1:0]   val;
    } operand_t;

    logic               busy [`RS_DEPTH];
    logic [IdxW-1:0]    age  [`RS_DEPTH];  // number of younger entries
    aluOp_e             op   [`RS_DEPTH];
    logic [`XLEN-1:0]   pc   [`RS_DEPTH];
    logic [`XLEN-1:0]   imm  [`RS_DEPTH];
    logic [`NICK_W-1:0] nick [`RS_DEPTH];
    operand_t           src1 [`RS_DEPTH];
    operand_t           src2 [`RS_DEPTH];

    logic [CredW-1:0]   credits;
    logic [IdxW-1:0]    freeIdx;
    logic [IdxW-1:0]    selIdx;
    logic [IdxW-1:0]    selAge;
    logic               haveFree;
    logic               haveReady;
    logic               accept;
    logic               issueFire;

    // capture a broadcast result into a waiting operand
    function automatic operand_t wake(input operand_t o);
        operand_t r;
        r = o;
        if (!o.valid && cdb.en && cdb.nick == o.tag) begin
            r.valid = 1'b1;
            r.val   = cdb.dt;
        end
        return r;
    endfunction

    // lowest free slot
    always_comb begin
        haveFree = 1'b0;
        freeIdx  = '0;
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                haveFree = 1'b1;
                freeIdx  = IdxW'(i);
            end
        end
    end

    // oldest entry with both operands in hand
    always_comb begin
        haveReady = 1'b0;
        selIdx    = '0;
        selAge    = '0;
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (busy[i] && src1[i].valid && src2[i].valid && (!haveReady || age[i] > selAge)) begin
                haveReady = 1'b1;
                selIdx    = IdxW'(i);
                selAge    = age[i];
            end
        end
    end

    assign dispFull  = !haveFree;
    assign accept    = dispEn && haveFree && rdy;
    assign issueFire = haveReady && credits != '0 && rdy;  // a queue slot is reserved

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RS_DEPTH; i++) begin
                busy[i] <= 1'b0;
            end
            credits  <= CredW'(`RQ_DEPTH);
            issue.en <= 1'b0;
        end else if (rdy) begin
            issue.en <= issueFire;
            credits  <= credits - CredW'(issueFire) + CredW'(popDone);

            for (int i = 0; i < `RS_DEPTH; i++) begin
                if (busy[i]) begin
                    src1[i] <= wake(src1[i]);
                    src2[i] <= wake(src2[i]);
                    age[i]  <= age[i] + IdxW'(accept) - IdxW'(issueFire && age[i] > selAge);
                end
            end

            if (issueFire) begin
                issue.pc     <= pc[selIdx];
                issue.op     <= op[selIdx];
                issue.imm    <= imm[selIdx];
                issue.nick   <= nick[selIdx];
                issue.rs1    <= src1[selIdx].val;
                issue.rs2    <= src2[selIdx].val;
                busy[selIdx] <= 1'b0;
            end

            if (accept) begin
                busy[freeIdx] <= 1'b1;
                age[freeIdx]  <= '0;
                op[freeIdx]   <= dispOp;
                pc[freeIdx]   <= dispPc;
                imm[freeIdx]  <= dispImm;
                nick[freeIdx] <= dispNick;
                // same-cycle broadcast is caught here too
                src1[freeIdx] <= wake(operand_t'{valid: !dispRs1Busy, tag: dispRs1Tag,
                                                 val: dispRs1Val});
                src2[freeIdx] <= wake(operand_t'{valid: !dispRs2Busy, tag: dispRs2Tag,
                                                 val: dispRs2Val});
            end
        end
    end

    // queue pops must never return more credits than were spent
    assert property (@(posedge clk) disable iff (rst) credits <= CredW'(`RQ_DEPTH));

    assert property (@(posedge clk) disable iff (rst)
        $past(rdy) && issue.en |-> $past(credits) != '0);

endmodule

// ==== design/aluBranchUnit.sv ====
`timescale 1ns/1ps
`include "execDefs_macros.svh"

module aluBranchUnit import execPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic rdy,
    issueIf.sink issue,
    cdbIf.src    cdb
);
    localparam int ShW = $clog2(`XLEN);

    logic [`XLEN-1:0] rs1;
    logic [`XLEN-1:0] rs2;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] seqPc;
    logic [`XLEN-1:0] brPc;
    logic [`XLEN-1:0] jalrSum;
    logic [ShW-1:0]   shImm;
    logic [ShW-1:0]   shReg;
    logic [`XLEN-1:0] dt;
    logic [`XLEN-1:0] jPc;
    jumpFlag_e        ac;
    logic             brTaken;

    assign rs1     = issue.rs1;
    assign rs2     = issue.rs2;
    assign imm     = issue.imm;
    assign seqPc   = issue.pc + `XLEN'(`PC_STEP);
    assign brPc    = issue.pc + imm;
    assign jalrSum = rs1 + imm;
    assign shImm   = imm[ShW-1:0];
    assign shReg   = rs2[ShW-1:0];

    always_comb begin
        dt      = '0;
        ac      = NotJump;
        jPc     = seqPc;
        brTaken = 1'b0;
        case (issue.op)
            LUI:   dt = imm;
            AUIPC: dt = issue.pc + imm;
            JAL: begin
                dt  = seqPc;
                ac  = Jump;
                jPc = brPc;
            end
            JALR: begin
                dt  = seqPc;
                ac  = Jump;
                jPc = {jalrSum[`XLEN-1:1], 1'b0};
            end
            BEQ:   brTaken = rs1 == rs2;
            BNE:   brTaken = rs1 != rs2;
            BLT:   brTaken = $signed(rs1) < $signed(rs2);
            BGE:   brTaken = $signed(rs1) >= $signed(rs2);
            BLTU:  brTaken = rs1 < rs2;
            BGEU:  brTaken = rs1 >= rs2;
            ADDI:  dt = rs1 + imm;
            SLTI:  dt = `XLEN'($signed(rs1) < $signed(imm));
            SLTIU: dt = `XLEN'(rs1 < imm);
            XORI:  dt = rs1 ^ imm;
            ORI:   dt = rs1 | imm;
            ANDI:  dt = rs1 & imm;
            SLLI:  dt = rs1 << shImm;
            SRLI:  dt = rs1 >> shImm;
            SRAI:  dt = $signed(rs1) >>> shImm;
            ADD:   dt = rs1 + rs2;
            SUB:   dt = rs1 - rs2;
            SLL:   dt = rs1 << shReg;
            SLT:   dt = `XLEN'($signed(rs1) < $signed(rs2));
            SLTU:  dt = `XLEN'(rs1 < rs2);
            XOR:   dt = rs1 ^ rs2;
            SRL:   dt = rs1 >> shReg;
            SRA:   dt = $signed(rs1) >>> shReg;
            OR:    dt = rs1 | rs2;
            AND:   dt = rs1 & rs2;
            default: dt = '0;
        endcase
        if (brTaken) begin  // branches leave dt at zero
            ac  = Jump;
            jPc = brPc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cdb.en <= 1'b0;
        end else if (rdy) begin
            cdb.en <= issue.en;
            if (issue.en) begin
                cdb.nick <= issue.nick;
                cdb.dt   <= dt;
                cdb.ac   <= ac;
                cdb.jPc  <= jPc;
            end
        end
    end

    // one broadcast per issue, exactly one edge later
    assert property (@(posedge clk) disable iff (rst)
        $past(rdy) |-> cdb.en == $past(issue.en));

endmodule

// ==== design/resultQueue.sv ====
`timescale 1ns/1ps
`include "execDefs_macros.svh"

module resultQueue import execPkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               rdy,
    cdbIf.snoop                cdb,
    output logic               resValid,
    output logic [`NICK_W-1:0] resNick,
    output logic [`XLEN-1:0]   resData,
    output jumpFlag_e          resTaken,
    output logic [`XLEN-1:0]   resNextPc,
    input  logic               resReady,
    output logic               popDone
);
    localparam int PtrW = $clog2(`RQ_DEPTH);
    localparam int CntW = $clog2(`RQ_DEPTH + 1);

    logic [`NICK_W-1:0] nickMem [`RQ_DEPTH];
    logic [`XLEN-1:0]   dtMem   [`RQ_DEPTH];
    jumpFlag_e          acMem   [`RQ_DEPTH];
    logic [`XLEN-1:0]   pcMem   [`RQ_DEPTH];

    logic [PtrW-1:0]    rdPtr;
    logic [PtrW-1:0]    wrPtr;
    logic [CntW-1:0]    count;
    logic               push;

    assign push     = cdb.en && rdy;
    assign resValid = count != '0;
    assign popDone  = resValid && resReady && rdy;  // also returns a credit

    assign resNick   = nickMem[rdPtr];
    assign resData   = dtMem[rdPtr];
    assign resTaken  = acMem[rdPtr];
    assign resNextPc = pcMem[rdPtr];

    always_ff @(posedge clk) begin
        if (rst) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                nickMem[wrPtr] <= cdb.nick;
                dtMem[wrPtr]   <= cdb.dt;
                acMem[wrPtr]   <= cdb.ac;
                pcMem[wrPtr]   <= cdb.jPc;
                wrPtr <= (wrPtr == PtrW'(`RQ_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (popDone) begin
                rdPtr <= (rdPtr == PtrW'(`RQ_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            count <= count + CntW'(push) - CntW'(popDone);
        end
    end

    // station credits keep the queue from overflowing
    assert property (@(posedge clk) disable iff (rst) push |-> count < CntW'(`RQ_DEPTH));

endmodule

// ==== design/execCluster.sv ====
`timescale 1ns/1ps
`include "execDefs_macros.svh"

module execCluster import execPkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               rdy,
    input  logic               dispEn,
    input  logic [`XLEN-1:0]   dispPc,
    input  aluOp_e             dispOp,
    input  logic [`XLEN-1:0]   dispImm,
    input  logic [`NICK_W-1:0] dispNick,
    input  logic [`XLEN-1:0]   dispRs1Val,
    input  logic [`NICK_W-1:0] dispRs1Tag,
    input  logic               dispRs1Busy,
    input  logic [`XLEN-1:0]   dispRs2Val,
    input  logic [`NICK_W-1:0] dispRs2Tag,
    input  logic               dispRs2Busy,
    output logic               dispFull,
    output logic               resValid,
    output logic [`NICK_W-1:0] resNick,
    output logic [`XLEN-1:0]   resData,
    output jumpFlag_e          resTaken,
    output logic [`XLEN-1:0]   resNextPc,
    input  logic               resReady
);
    issueIf issueBus ();
    cdbIf   cdbBus ();
    logic   popDone;   // credit return, queue to station

    reservationStation rs (
        .clk, .rst, .rdy,
        .dispEn, .dispPc, .dispOp, .dispImm, .dispNick,
        .dispRs1Val, .dispRs1Tag, .dispRs1Busy,
        .dispRs2Val, .dispRs2Tag, .dispRs2Busy,
        .dispFull,
        .popDone,
        .issue (issueBus.src),
        .cdb   (cdbBus.snoop)
    );

    aluBranchUnit alu (
        .clk, .rst, .rdy,
        .issue (issueBus.sink),
        .cdb   (cdbBus.src)
    );

    resultQueue rq (
        .clk, .rst, .rdy,
        .cdb   (cdbBus.snoop),
        .resValid, .resNick, .resData, .resTaken, .resNextPc,
        .resReady,
        .popDone
    );

endmodule

// ==== verification/tbExecCluster.sv ====
`timescale 1ns/1ps
`include "execDefs_macros.svh"

module tbExecCluster import execPkg::*; ();
    // roughly 80 dispatches at two cycles each plus drains and the stall
    localparam int MaxCycles = 2000;

    logic               clk;
    logic               rst;
    logic               rdy;
    logic               dispEn;
    logic [`XLEN-1:0]   dispPc;
    aluOp_e             dispOp;
    logic [`XLEN-1:0]   dispImm;
    logic [`NICK_W-1:0] dispNick;
    logic [`XLEN-1:0]   dispRs1Val;
    logic [`NICK_W-1:0] dispRs1Tag;
    logic               dispRs1Busy;
    logic [`XLEN-1:0]   dispRs2Val;
    logic [`NICK_W-1:0] dispRs2Tag;
    logic               dispRs2Busy;
    logic               dispFull;
    logic               resValid;
    logic [`NICK_W-1:0] resNick;
    logic [`XLEN-1:0]   resData;
    jumpFlag_e          resTaken;
    logic [`XLEN-1:0]   resNextPc;
    logic               resReady;

    // model results by nick
    logic [`XLEN-1:0]        expData  [1<<`NICK_W];
    jumpFlag_e               expTaken [1<<`NICK_W];
    logic [`XLEN-1:0]        expPc    [1<<`NICK_W];
    logic [(1<<`NICK_W)-1:0] inFlight;
    logic [`NICK_W-1:0]      nextNick;
    int                      dispatched;
    logic                    sawFull;
    logic                    popNow;
    integer                  seed;
    int                      valueErrors = 0;
    int                      otherErrors = 0;
    int                      cycles;
    string                   testName = "reset";

    aluOp_e           brOps [6] = '{BEQ, BNE, BLT, BGE, BLTU, BGEU};
    logic [`XLEN-1:0] pairA [3] = '{32'h1234_5678, 32'hffff_fff0, 32'h0000_0010};
    logic [`XLEN-1:0] pairB [3] = '{32'h1234_5678, 32'h0000_0010, 32'hffff_fff0};

    execCluster DUT (.*);

    assign popNow = resValid && resReady && rdy;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < MaxCycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, nicks still in flight: %h", cycles, inFlight);
        $display("value errors: %0d, other errors: %0d", valueErrors, otherErrors);
        $display("TEST FAILED");
        $finish;
    end

    // tracks what the DUT accepted and returned
    always @(posedge clk) begin
        if (rst) begin
            inFlight   <= '0;
            dispatched <= 0;
            sawFull    <= 1'b0;
        end else if (rdy) begin
            if (dispEn && !dispFull) begin
                inFlight[dispNick] <= 1'b1;
                dispatched         <= dispatched + 1;
            end
            if (popNow) inFlight[resNick] <= 1'b0;
            if (dispFull) sawFull <= 1'b1;
        end
    end

    task automatic logMismatch(input string what, input logic [`XLEN-1:0] exp, act);
        valueErrors++;
        $display("Error %s: %s expected %h actual %h", testName, what, exp, act);
    endtask

    task automatic reportProblem(input string msg);
        otherErrors++;
        $display("%s: %s", testName, msg);
    endtask

    // checked at the falling edge, where everything driven at the rising edge has settled
    assert property (@(negedge clk) disable iff (rst) dispatched == 0 |-> !resValid && !dispFull)
        else reportProblem("result or full flag active before any dispatch");
    assert property (@(negedge clk) disable iff (rst) popNow |-> inFlight[resNick])
        else reportProblem($sformatf("result for nick %0d with nothing in flight", resNick));
    assert property (@(negedge clk) disable iff (rst) popNow |-> resData == expData[resNick])
        else logMismatch("data", expData[resNick], resData);
    assert property (@(negedge clk) disable iff (rst) popNow |-> resTaken == expTaken[resNick])
        else logMismatch("taken", {31'b0, expTaken[resNick]}, {31'b0, resTaken});
    assert property (@(negedge clk) disable iff (rst) popNow |-> resNextPc == expPc[resNick])
        else logMismatch("next pc", expPc[resNick], resNextPc);

    function automatic void computeExpected(input aluOp_e op,
                                            input logic [`XLEN-1:0] pc, imm, a, b,
                                            output logic [`XLEN-1:0] data,
                                            output jumpFlag_e taken,
                                            output logic [`XLEN-1:0] nextPc);
        logic signed [`XLEN-1:0] sa;
        logic signed [`XLEN-1:0] sb;
        logic signed [`XLEN-1:0] si;
        logic                    cond;
        sa     = a;
        sb     = b;
        si     = imm;
        cond   = 1'b0;
        data   = '0;
        taken  = NotJump;
        nextPc = pc + 32'd4;
        case (op)
            LUI:       data = imm;
            AUIPC:     data = pc + imm;
            JAL, JALR: data = pc + 32'd4;
            ADDI:      data = a + imm;
            SLTI:      data = (sa < si) ? 32'd1 : 32'd0;
            SLTIU:     data = (a < imm) ? 32'd1 : 32'd0;
            XORI:      data = a ^ imm;
            ORI:       data = a | imm;
            ANDI:      data = a & imm;
            SLLI:      data = a << imm[4:0];
            SRLI:      data = a >> imm[4:0];
            SRAI:      data = sa >>> imm[4:0];
            ADD:       data = a + b;
            SUB:       data = a - b;
            SLL:       data = a << b[4:0];
            SLT:       data = (sa < sb) ? 32'd1 : 32'd0;
            SLTU:      data = (a < b) ? 32'd1 : 32'd0;
            XOR:       data = a ^ b;
            SRL:       data = a >> b[4:0];
            SRA:       data = sa >>> b[4:0];
            OR:        data = a | b;
            AND:       data = a & b;
            BEQ:       cond = a == b;
            BNE:       cond = a != b;
            BLT:       cond = sa < sb;
            BGE:       cond = sa >= sb;
            BLTU:      cond = a < b;
            BGEU:      cond = a >= b;
            default:   data = '0;
        endcase
        if (op == JAL || cond) begin
            taken  = Jump;
            nextPc = pc + imm;
        end else if (op == JALR) begin
            taken  = Jump;
            nextPc = (a + imm) & 32'hffff_fffe;
        end
    endfunction

    task automatic dispatch(input aluOp_e op, input logic [`XLEN-1:0] pc, imm, a, b,
                            input logic aBusy, input logic [`NICK_W-1:0] aTag,
                            input logic bBusy, input logic [`NICK_W-1:0] bTag,
                            output logic [`NICK_W-1:0] nick);
        nick     = nextNick;
        nextNick = nextNick + `NICK_W'(1);
        @(negedge clk);
        while (inFlight[nick]) @(negedge clk);
        computeExpected(op, pc, imm, a, b, expData[nick], expTaken[nick], expPc[nick]);
        @(posedge clk);
        dispEn      <= 1'b1;
        dispPc      <= pc;
        dispOp      <= op;
        dispImm     <= imm;
        dispNick    <= nick;
        dispRs1Val  <= aBusy ? ~a : a;  // stale value while busy
        dispRs1Tag  <= aTag;
        dispRs1Busy <= aBusy;
        dispRs2Val  <= bBusy ? ~b : b;
        dispRs2Tag  <= bTag;
        dispRs2Busy <= bBusy;
        @(negedge clk);
        while (dispFull) @(negedge clk);
        @(posedge clk);  // taken on this edge
        dispEn <= 1'b0;
    endtask

    task automatic dispatchReady(input aluOp_e op, input logic [`XLEN-1:0] pc, imm, a, b);
        logic [`NICK_W-1:0] unusedNick;
        dispatch(op, pc, imm, a, b, 1'b0, '0, 1'b0, '0, unusedNick);
    endtask

    task automatic waitAllReturned();
        @(negedge clk);
        while (inFlight != '0) @(negedge clk);
    endtask

    initial begin
        int                 i;
        int                 k;
        int                 p;
        int                 fillWait;
        logic [4:0]         code;
        logic [`XLEN-1:0]   pcV;
        logic [`XLEN-1:0]   immV;
        logic [`XLEN-1:0]   aV;
        logic [`XLEN-1:0]   bV;
        logic [`NICK_W-1:0] np;
        logic [`NICK_W-1:0] nc;
        logic [`NICK_W-1:0] nw;
        seed        = 32'hdbb0_9f28;
        nextNick    = '0;
        rst         <= 1'b1;
        rdy         <= 1'b1;
        dispEn      <= 1'b0;
        dispPc      <= '0;
        dispOp      <= ADD;
        dispImm     <= '0;
        dispNick    <= '0;
        dispRs1Val  <= '0;
        dispRs1Tag  <= '0;
        dispRs1Busy <= 1'b0;
        dispRs2Val  <= '0;
        dispRs2Tag  <= '0;
        dispRs2Busy <= 1'b0;
        resReady    <= 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        repeat (5) @(posedge clk);  // idle before the first dispatch

        testName = "randomAlu";
        for (i = 0; i < 40; i++) begin
            code = 5'($unsigned($random(seed)) % 21);
            if (code >= 5'd2) code = code + 5'd8;  // skip jumps and branches
            pcV  = $random(seed);
            immV = $random(seed);
            aV   = $random(seed);
            bV   = $random(seed);
            dispatchReady(aluOp_e'(code), pcV & 32'hffff_fffc, immV, aV, bV);
        end
        waitAllReturned();

        testName = "branch";
        for (k = 0; k < 6; k++) begin
            for (p = 0; p < 3; p++) begin
                immV = (p == 1) ? 32'hffff_ff80 : 32'h0000_0100;
                pcV  = 32'h0000_2000 + 32'(k * 64 + p * 4);
                dispatchReady(brOps[k], pcV, immV, pairA[p], pairB[p]);
            end
        end
        waitAllReturned();

        testName = "jump";
        dispatchReady(JAL, 32'h0000_1000, 32'h0000_0800, '0, '0);
        dispatchReady(JAL, 32'h0000_3000, 32'hffff_f000, '0, '0);
        dispatchReady(JALR, 32'h0000_1100, 32'h0000_0011, 32'h0000_2002, '0);
        dispatchReady(JALR, 32'h0000_1200, 32'hffff_fff0, 32'h8000_0001, '0);
        waitAllReturned();

        // consumers wait on the producer broadcast
        testName = "wakeup";
        dispatch(ADDI, 32'h0000_4000, 32'h0000_0123, 32'h0001_0000, '0,
                 1'b0, '0, 1'b0, '0, np);
        dispatch(ADD, 32'h0000_4004, '0, expData[np], 32'h0000_0007,
                 1'b1, np, 1'b0, '0, nc);
        dispatch(SUB, 32'h0000_4008, '0, 32'h0010_0000, expData[nc],
                 1'b0, '0, 1'b1, nc, nw);
        waitAllReturned();

        testName = "backPressure";
        @(posedge clk);
        resReady <= 1'b0;
        fork
            begin
                for (i = 0; i < 10; i++) begin
                    aV = $random(seed);
                    bV = $random(seed);
                    dispatchReady(XOR, 32'h0000_5000 + 32'(i * 4), '0, aV, bV);
                end
            end
            begin
                fillWait = 0;
                @(negedge clk);
                while (!dispFull && fillWait < 40) begin
                    @(negedge clk);
                    fillWait++;
                end
                repeat (6) @(posedge clk);
                resReady <= 1'b1;
            end
        join
        waitAllReturned();
        assert (sawFull) else reportProblem("dispFull never rose while results were held");

        $display("value errors: %0d, other errors: %0d", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+design
design/execPkg.sv
design/issueIf.sv
design/cdbIf.sv
design/reservationStation.sv
design/aluBranchUnit.sv
design/resultQueue.sv
design/execCluster.sv
verification/tbExecCluster.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tbExecCluster
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TEST OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the status comes from the search for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
